// ==== verilog/hist_pkg.sv ====
`default_nettype none

package hist_pkg;

    localparam int lanes = 4;               // histogram lanes fed round-robin
    localparam int sym_w = 8;
    localparam int cnt_w = 32;
    localparam logic [sym_w-1:0] eof_sym = 8'h1A;   // ctrl-z closes a file

    typedef logic [cnt_w-1:0] count_t;

    typedef struct packed {
        logic             valid;
        logic [sym_w-1:0] sym;
    } lane_cmd_t;

    typedef struct packed {
        logic             valid;
        logic [sym_w-1:0] addr;
        logic             clear;            // zero the entry once it is read
    } sweep_req_t;

    typedef struct packed {
        logic             valid;
        logic [sym_w-1:0] sym;
        count_t           count;
    } hist_out_t;

    typedef enum logic [1:0] {
        LANE_IDLE  = 2'd0,
        LANE_READ  = 2'd1,
        LANE_WRITE = 2'd2,
        LANE_SWEEP = 2'd3
    } lane_state_t;

    typedef enum logic [2:0] {
        M_CLEAR = 3'd0,
        M_IDLE  = 3'd1,
        M_DRAIN = 3'd2,
        M_SWEEP = 3'd3,
        M_DONE  = 3'd4
    } merge_state_t;

endpackage

`default_nettype wire

// ==== verilog/count_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module count_ram (
    input  logic                       clk,
    input  logic [hist_pkg::sym_w-1:0] rd_addr,
    output hist_pkg::count_t           rd_data,
    input  logic                       wr_en,
    input  logic [hist_pkg::sym_w-1:0] wr_addr,
    input  hist_pkg::count_t           wr_data
);
    import hist_pkg::*;

    count_t mem [2**sym_w];                 // one count per symbol

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read returns old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/byte_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module byte_dispatch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [hist_pkg::sym_w-1:0] in_byte,
    input  logic                       idle,
    output hist_pkg::lane_cmd_t        cmd [hist_pkg::lanes],
    output logic                       eof_seen,
    output hist_pkg::count_t           total
);
    import hist_pkg::*;

    logic             accept;
    logic             is_eof;
    logic [1:0]       ptr;                  // next lane to receive a byte
    logic             first;                // next accepted byte opens a file
    logic [lanes-1:0] cmd_vld;
    logic [sym_w-1:0] sym_q;                // one symbol register serves all lanes

    assign accept = in_valid && idle;       // merge drops idle from eof_seen on
    assign is_eof = (in_byte == eof_sym);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ptr      <= '0;
            first    <= 1'b1;
            eof_seen <= 1'b0;
            total    <= '0;
            cmd_vld  <= '0;
        end else begin
            eof_seen <= accept && is_eof;
            for (int i = 0; i < lanes; i++) begin
                cmd_vld[i] <= accept && (ptr == i[1:0]);
            end
            if (accept) begin
                ptr   <= is_eof ? 2'd0 : ptr + 2'd1;    // every file starts on lane 0
                total <= first ? count_t'(1) : total + 1'b1;
                first <= is_eof;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sym_q <= in_byte;
        end
    end

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            cmd[i] = '{valid: cmd_vld[i], sym: sym_q};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hist_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module hist_lane (
    input  logic                 clk,
    input  logic                 rst,
    input  hist_pkg::lane_cmd_t  cmd,
    input  hist_pkg::sweep_req_t sweep,
    output hist_pkg::count_t     rd_count,
    output logic                 busy
);
    import hist_pkg::*;

    lane_state_t      state;
    logic [sym_w-1:0] sym_q;                // symbol being incremented
    logic [sym_w-1:0] swp_addr_q;           // address read by the sweep last cycle
    logic             swp_clr_q;
    logic [sym_w-1:0] rd_addr;
    logic             wr_en;
    logic [sym_w-1:0] wr_addr;
    count_t           wr_data;

    count_ram u_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_count),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    assign busy    = (state == LANE_READ) || (state == LANE_WRITE);
    assign rd_addr = sweep.valid ? sweep.addr : sym_q;  // sweep never overlaps an update

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= LANE_IDLE;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (cmd.valid) begin
                        state <= LANE_READ;
                    end else if (sweep.valid) begin
                        state <= LANE_SWEEP;
                    end
                end
                LANE_READ:  state <= LANE_WRITE;    // count arrives from the RAM
                LANE_WRITE: state <= LANE_IDLE;
                LANE_SWEEP: begin
                    // stays one cycle past the last address to clear it
                    if (!sweep.valid) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            sym_q <= cmd.sym;
        end
        swp_addr_q <= sweep.addr;
        swp_clr_q  <= sweep.valid && sweep.clear;
    end

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = sym_q;
        wr_data = rd_count + 1'b1;
        case (state)
            LANE_WRITE: wr_en = 1'b1;
            LANE_SWEEP: begin
                wr_en   = swp_clr_q;
                wr_addr = swp_addr_q;
                wr_data = '0;
            end
            default: wr_en = 1'b0;
        endcase
    end

    // round-robin spacing from the dispatcher keeps commands off a busy lane
    a_no_cmd_while_busy: assert property (
        @(posedge clk) disable iff (rst) cmd.valid |-> !busy
    ) else $error("hist_lane: command received during read-modify-write");

endmodule

`default_nettype wire

// ==== verilog/hist_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module hist_merge (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       eof_seen,
    input  logic [hist_pkg::lanes-1:0] lane_busy,
    input  hist_pkg::count_t           lane_count [hist_pkg::lanes],
    output hist_pkg::sweep_req_t       sweep,
    output hist_pkg::hist_out_t        result,
    output logic                       done,
    output logic                       idle
);
    import hist_pkg::*;

    merge_state_t     state;
    logic             issue;                // address generator running
    logic [sym_w-1:0] addr;
    logic             drained;
    logic             p1_valid;             // lane read stage
    logic             p1_show;
    logic [sym_w-1:0] p1_sym;
    count_t           lane_sum;
    logic             res_valid;            // sum stage
    logic [sym_w-1:0] res_sym;
    count_t           res_count;

    assign drained = !issue && !p1_valid;   // last address has left the lanes
    assign sweep   = '{valid: issue, addr: addr, clear: issue};
    assign result  = '{valid: res_valid, sym: res_sym, count: res_count};
    assign done    = (state == M_DONE);
    assign idle    = ((state == M_IDLE) && !eof_seen) || (state == M_DONE);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= M_CLEAR;
            issue <= 1'b1;                  // lane RAMs start unknown
            addr  <= '0;
        end else begin
            if (issue) begin
                addr <= addr + 1'b1;        // wraps back to 0 after symbol 255
                if (addr == '1) begin
                    issue <= 1'b0;
                end
            end
            case (state)
                M_CLEAR: if (drained) state <= M_IDLE;
                M_IDLE:  if (eof_seen) state <= M_DRAIN;
                M_DRAIN: begin
                    if (lane_busy == '0) begin
                        state <= M_SWEEP;
                        issue <= 1'b1;
                    end
                end
                M_SWEEP: if (drained) state <= M_DONE;
                M_DONE:  state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < lanes; i++) begin
            lane_sum = lane_sum + lane_count[i];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            p1_valid  <= 1'b0;
            p1_show   <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            p1_valid  <= issue;
            p1_show   <= issue && (state == M_SWEEP); // clear sweep stays hidden
            res_valid <= p1_valid && p1_show;
        end
    end

    always_ff @(posedge clk) begin
        p1_sym    <= addr;
        res_sym   <= p1_sym;
        res_count <= lane_sum;
    end

    // the sweep shares the lane RAM ports with pending increments
    a_sweep_lanes_quiet: assert property (
        @(posedge clk) disable iff (rst) sweep.valid |-> (lane_busy == '0)
    ) else $error("hist_merge: sweep issued while a lane is busy");

endmodule

`default_nettype wire

// ==== verilog/hist_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module hist_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [hist_pkg::sym_w-1:0] in_byte,
    output hist_pkg::hist_out_t        result,
    output logic                       done,
    output hist_pkg::count_t           total,
    output logic                       idle
);
    import hist_pkg::*;

    lane_cmd_t        cmd [lanes];
    logic             eof_seen;
    logic [lanes-1:0] lane_busy;
    count_t           lane_count [lanes];
    sweep_req_t       sweep;                // broadcast to every lane

    byte_dispatch u_dispatch (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_byte  (in_byte),
        .idle     (idle),
        .cmd      (cmd),
        .eof_seen (eof_seen),
        .total    (total)
    );

    for (genvar g = 0; g < lanes; g++) begin : g_lane
        hist_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .cmd      (cmd[g]),
            .sweep    (sweep),
            .rd_count (lane_count[g]),
            .busy     (lane_busy[g])
        );
    end

    hist_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .eof_seen   (eof_seen),
        .lane_busy  (lane_busy),
        .lane_count (lane_count),
        .sweep      (sweep),
        .result     (result),
        .done       (done),
        .idle       (idle)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_hist_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_hist_top;
    import hist_pkg::*;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [sym_w-1:0] in_byte;
    hist_out_t        result;
    logic             done;
    count_t           total;
    logic             idle;

    integer           seed;
    int               errors;
    int               timeouts;
    logic             armed;                // monitor runs once the clear sweep is over
    logic             file_phase;           // high while the bytes of a file are strobed
    logic             done_q;
    int               res_cnt;              // results seen in the current sweep
    hist_out_t        exp_res;
    count_t           model_cnt [256];
    count_t           model_total;
    int               len;
    int               gap_max;

    hist_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_byte  (in_byte),
        .result   (result),
        .done     (done),
        .total    (total),
        .idle     (idle)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_result(input hist_out_t got, input hist_out_t exp);
        if (got.sym !== exp.sym) begin
            errors++;
            $display("CHECK FAILED result.sym: got %h, expected %h", got.sym, exp.sym);
        end
        if (got.count !== exp.count) begin
            errors++;
            $display("CHECK FAILED result.count for symbol %h: got %h, expected %h",
                     exp.sym, got.count, exp.count);
        end
    endtask

    task automatic check_total(input count_t got, input count_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED total: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // any byte but the end-of-file marker
    task automatic pick_symbol(output logic [sym_w-1:0] b);
        integer r;
        r = $random(seed);
        while (r[7:0] == eof_sym) begin
            r = $random(seed);
        end
        b = r[7:0];
    endtask

    task automatic clear_model();
        for (int s = 0; s < 256; s++) begin
            model_cnt[s] = '0;
        end
        model_total = '0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_flag("idle", idle, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("result.valid", result.valid, 1'b0);
        check_total(total, '0);
    endtask

    task automatic wait_clear_sweep();
        int n;
        n = 0;
        @(negedge clk);
        while (!idle && n < 1000) begin
            if (result.valid) begin
                errors++;
                $display("a result was shown during the clear sweep after reset");
            end
            if (done) begin
                errors++;
                $display("done pulsed during the clear sweep after reset");
            end
            @(negedge clk);
            n++;
        end
        if (!idle) begin
            timeouts++;
            $display("timeout: idle did not rise after reset within 1000 cycles");
        end else if (n < 256) begin
            errors++;
            $display("idle rose %0d cycles after reset, too early for a full sweep", n);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!idle && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!idle) begin
            timeouts++;
            $display("timeout: idle did not rise within 100 cycles");
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            timeouts++;
            $display("timeout: done did not pulse within 2000 cycles");
        end
    endtask

    task automatic send_file(input int n_bytes, input int max_gap);
        logic [sym_w-1:0] b;
        int               gap;
        integer           r;
        for (int i = 0; i < n_bytes; i++) begin
            if (i == n_bytes - 1) begin
                b = eof_sym;
            end else begin
                pick_symbol(b);
            end
            @(posedge clk);
            in_valid   <= 1'b1;
            in_byte    <= b;
            file_phase <= 1'b1;
            model_cnt[b] = model_cnt[b] + 1;
            model_total  = model_total + 1;
            if (i != n_bytes - 1) begin
                gap = (max_gap == 0) ? 0 : ({$random(seed)} % (max_gap + 1));
                repeat (gap) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                end
            end
        end
        // idle is low from here on, so these must not be counted
        repeat (16) begin
            r = $random(seed);
            @(posedge clk);
            in_valid   <= 1'b1;
            in_byte    <= r[7:0];
            file_phase <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic run_file(input int n_bytes, input int max_gap);
        wait_idle();
        if (timeouts == 0) begin
            clear_model();
            send_file(n_bytes, max_gap);
            wait_done();
        end
    endtask

    // checks the result stream, done and byte acceptance mid-cycle
    always @(negedge clk) begin
        if (armed) begin
            if (in_valid && file_phase && !idle) begin
                errors++;
                $display("a byte of the file was strobed while idle was low");
            end
            if (in_valid && !file_phase && idle) begin
                errors++;
                $display("a byte strobed after end of file met idle high");
            end
            if (result.valid) begin
                if (res_cnt >= 256) begin
                    errors++;
                    $display("more than 256 results in one sweep");
                end else begin
                    exp_res.valid = 1'b1;
                    exp_res.sym   = res_cnt[7:0];
                    exp_res.count = model_cnt[res_cnt];
                    check_result(result, exp_res);
                end
                res_cnt++;
            end else if (res_cnt > 0 && res_cnt < 256) begin
                errors++;
                $display("result stream stopped after %0d symbols", res_cnt);
            end
            if (done) begin
                check_total(total, model_total);
                check_flag("idle", idle, 1'b1);
                if (res_cnt != 256) begin
                    errors++;
                    $display("sweep gave %0d results instead of 256", res_cnt);
                end
                if (done_q) begin
                    errors++;
                    $display("done stayed high for more than one cycle");
                end
                res_cnt = 0;
            end
            done_q = done;
        end
    end

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_byte    = '0;
        seed       = 10;
        errors     = 0;
        timeouts   = 0;
        armed      = 1'b0;
        file_phase = 1'b0;
        done_q     = 1'b0;
        res_cnt    = 0;
        clear_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        wait_clear_sweep();
        armed = 1'b1;
        // three back-to-back files, three with gaps, a lone eof byte, one more
        for (int f = 0; f < 8 && timeouts == 0; f++) begin
            if (f == 6) begin
                len = 1;
            end else begin
                len = 50 + ({$random(seed)} % 351);
            end
            if (f < 3) begin
                gap_max = 0;
            end else if (f < 6) begin
                gap_max = 3;
            end else begin
                gap_max = 2;
            end
            run_file(len, gap_max);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/hist_pkg.sv
verilog/count_ram.sv
verilog/byte_dispatch.sv
verilog/hist_lane.sv
verilog/hist_merge.sv
verilog/hist_top.sv
testbench/tb_hist_top.sv

// ==== Makefile ====
# sources are taken from the file list so the binary tracks every change
SRCS := $(filter-out +%,$(shell cat vlog.f))

.PHONY: run clean

run: obj_dir/Vtb_hist_top
	obj_dir/Vtb_hist_top | tee sim.log
	grep -q "Verification passed" sim.log

obj_dir/Vtb_hist_top: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		--top-module tb_hist_top -f vlog.f

clean:
	rm -rf obj_dir sim.log
